/* include/ma_wb_defines.svh */
`ifndef MA_WB_DEFINES_SVH
`define MA_WB_DEFINES_SVH

// data word and packet widths
`define MA_DATA_W       16
`define MA_PACKET_W     40

// upper packet field, carried through both stages untouched
`define MA_OTHER_W      24

// data memory geometry
`define MA_DMEM_DEPTH   1024
`define MA_DMEM_ADDR_W  10

// register file geometry
`define MA_REG_COUNT    16
`define MA_REG_ADDR_W   4

// destination register index sits just above the result field
`define MA_REG_DEST_LSB 16

// packet bit asking for a register write at hand-off
`define MA_REG_WE_BIT   20

`endif

/* ma_wb.f */
+incdir+include
rtl/ma_wb_pkg.sv
rtl/mem_port_if.sv
rtl/stage_ctrl.sv
rtl/data_mem.sv
rtl/ma_stage.sv
rtl/wb_stage.sv
rtl/ma_wb_top.sv
testbench/tb_ma_wb.sv

/* rtl/data_mem.sv */
`include "ma_wb_defines.svh"

// single-port data memory
// read is registered, a write leaves rdata as it was
module data_mem import ma_wb_pkg::*; (
    input logic CP,
    mem_port_if.mem mem
);

    // block ram style array, contents undefined at power-up
    data_t ram [`MA_DMEM_DEPTH];

    always_ff @(posedge CP) begin
        if (mem.en) begin
            if (mem.we) begin
                ram[mem.addr] <= mem.wdata;
            end else begin
                // read first word of the addressed location
                mem.rdata <= ram[mem.addr];
            end
        end
    end

    // writes only happen as part of an enabled access
    a_we_needs_en : assert property (
        @(posedge CP)
        mem.we |-> mem.en
    );

endmodule

/* rtl/ma_stage.sv */
`include "ma_wb_defines.svh"

// memory-access stage
// latches the packet and load flag, reads or writes the data memory,
// then merges the loaded word into the outgoing packet
module ma_stage import ma_wb_pkg::*; (
    input  logic    CP,
    input  logic    MR,
    // upstream link
    input  logic    send_in,
    output logic    ack_out,
    // downstream link
    output logic    send_out,
    input  logic    ack_in,
    // access control from execute
    input  logic    load_flg,
    input  logic    write_en,
    input  data_t   write_data,
    // packets
    input  packet_t packet_in,
    output packet_t packet_out,
    // data memory port
    mem_port_if.stage mem
);

    logic    capture;
    logic    load_q;
    packet_t packet_q;
    other_t  other_q;
    packet_t merged;

    stage_ctrl i_ctrl (
        .CP       (CP),
        .MR       (MR),
        .send_in  (send_in),
        .ack_out  (ack_out),
        .send_out (send_out),
        .ack_in   (ack_in),
        .capture  (capture)
    );

    // packet latch with its load flag
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            load_q   <= 1'b0;
            packet_q <= '0;
        end else if (capture) begin
            load_q   <= load_flg;
            packet_q <= packet_in;
        end
    end

    // memory only moves on capture edges
    // so rdata stays put while the stage stalls
    assign mem.en    = capture;
    assign mem.we    = capture && write_en;
    // address from the low result bits of the incoming packet
    assign mem.addr  = packet_in[`MA_DMEM_ADDR_W-1:0];
    assign mem.wdata = write_data;

    // load result replaces the address field
    assign other_q = packet_q[`MA_PACKET_W-1:`MA_DATA_W];
    assign merged  = {other_q, mem.rdata};

    assign packet_out = load_q ? merged : packet_q;

    // one access per packet, either load or store
    a_load_xor_store : assert property (
        @(posedge CP) disable iff (MR)
        capture |-> !(load_flg && write_en)
    );

endmodule

/* rtl/ma_wb_pkg.sv */
`include "ma_wb_defines.svh"

package ma_wb_pkg;

    // one data word, also the register file entry width
    typedef logic [`MA_DATA_W-1:0] data_t;

    // full stage packet
    // bits 39..16 other field, bits 15..0 result or address
    typedef logic [`MA_PACKET_W-1:0] packet_t;

    // upper field of the packet
    typedef logic [`MA_OTHER_W-1:0] other_t;

    // word address into the data memory
    typedef logic [`MA_DMEM_ADDR_W-1:0] dmem_addr_t;

    // register file index
    typedef logic [`MA_REG_ADDR_W-1:0] reg_addr_t;

endpackage

/* rtl/ma_wb_top.sv */
`include "ma_wb_defines.svh"

// back end of the pipeline
// memory access, then write back, with the data memory beside them
module ma_wb_top import ma_wb_pkg::*; (
    input  logic      CP,
    input  logic      MR,
    // from execute
    input  logic      send_in,
    output logic      ack_out,
    input  logic      load_flg,
    input  logic      write_en,
    input  data_t     write_data,
    input  packet_t   packet_in,
    // to the downstream consumer
    output logic      send_out,
    input  logic      ack_in,
    output packet_t   packet_out,
    // register read port for decode
    input  reg_addr_t rd_addr,
    output data_t     rd_data
);

    // link between the two stages
    logic    ma_send;
    logic    wb_ack;
    packet_t ma_packet;

    // data memory port
    mem_port_if mem_bus ();

    ma_stage i_ma (
        .CP         (CP),
        .MR         (MR),
        .send_in    (send_in),
        .ack_out    (ack_out),
        .send_out   (ma_send),
        .ack_in     (wb_ack),
        .load_flg   (load_flg),
        .write_en   (write_en),
        .write_data (write_data),
        .packet_in  (packet_in),
        .packet_out (ma_packet),
        .mem        (mem_bus.stage)
    );

    data_mem i_mem (
        .CP  (CP),
        .mem (mem_bus.mem)
    );

    wb_stage i_wb (
        .CP         (CP),
        .MR         (MR),
        .send_in    (ma_send),
        .ack_out    (wb_ack),
        .send_out   (send_out),
        .ack_in     (ack_in),
        .packet_in  (ma_packet),
        .packet_out (packet_out),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

/* rtl/mem_port_if.sv */
`include "ma_wb_defines.svh"

// data memory port between the memory-access stage and the RAM
interface mem_port_if import ma_wb_pkg::*; ();

    // read enable, write enable
    logic       en;
    logic       we;
    // word address and store data
    dmem_addr_t addr;
    data_t      wdata;
    // registered read data back from the RAM
    data_t      rdata;

    // stage side drives the request
    modport stage (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // ram side samples the request
    modport mem (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* rtl/stage_ctrl.sv */
// synchronous send/ack controller for one pipeline stage
// full flag says the stage latch holds a packet not yet handed on
module stage_ctrl (
    input  logic CP,
    input  logic MR,
    // upstream link
    input  logic send_in,
    output logic ack_out,
    // downstream link
    output logic send_out,
    input  logic ack_in,
    // load enable for the stage latch
    output logic capture
);

    logic full;
    logic handoff;

    // packet leaves on this edge
    assign handoff = full && ack_in;

    // room when empty, or when the held packet drains this cycle
    assign ack_out = !full || ack_in;

    // transfer in on send and ack together
    assign capture = send_in && ack_out;

    // offer downstream while holding a packet
    assign send_out = full;

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            full <= 1'b0;
        end else if (capture) begin
            // new packet, possibly replacing one that drains
            full <= 1'b1;
        end else if (handoff) begin
            // drained with nothing behind it
            full <= 1'b0;
        end
    end

    // producer keeps offering until the stage takes the packet
    a_send_held : assert property (
        @(posedge CP) disable iff (MR)
        (send_in && !ack_out) |=> send_in
    );

endmodule

/* rtl/wb_stage.sv */
`include "ma_wb_defines.svh"

// write-back stage
// holds the packet and commits its result to the register file
// on the edge where the packet is handed downstream
module wb_stage import ma_wb_pkg::*; (
    input  logic      CP,
    input  logic      MR,
    // upstream link
    input  logic      send_in,
    output logic      ack_out,
    // downstream link
    output logic      send_out,
    input  logic      ack_in,
    // packets
    input  packet_t   packet_in,
    output packet_t   packet_out,
    // read port for decode
    input  reg_addr_t rd_addr,
    output data_t     rd_data
);

    logic      capture;
    logic      handoff;
    packet_t   packet_q;
    reg_addr_t dest;
    logic      reg_we;
    data_t     regs [`MA_REG_COUNT];

    stage_ctrl i_ctrl (
        .CP       (CP),
        .MR       (MR),
        .send_in  (send_in),
        .ack_out  (ack_out),
        .send_out (send_out),
        .ack_in   (ack_in),
        .capture  (capture)
    );

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            packet_q <= '0;
        end else if (capture) begin
            packet_q <= packet_in;
        end
    end

    assign packet_out = packet_q;

    // fields of the held packet
    assign dest    = packet_q[`MA_REG_DEST_LSB +: `MA_REG_ADDR_W];
    assign reg_we  = packet_q[`MA_REG_WE_BIT];
    assign handoff = send_out && ack_in;

    // commit at hand-off, only when the packet asks for it
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            for (int i = 0; i < `MA_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (handoff && reg_we) begin
            regs[dest] <= packet_q[`MA_DATA_W-1:0];
        end
    end

    // combinational read, new value visible right after the commit
    assign rd_data = regs[rd_addr];

    // stalled packet must hold still for the consumer
    a_stall_stable : assert property (
        @(posedge CP) disable iff (MR)
        (send_out && !ack_in) |=> $stable(packet_out)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the ma_wb testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f ma_wb.f --top-module tb_ma_wb -o sim_ma_wb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ma_wb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* testbench/tb_ma_wb.sv */
`include "ma_wb_defines.svh"

module tb_ma_wb import ma_wb_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 2000;
    localparam int RND_COUNT  = 200;
    // consumer ack patterns
    localparam int ACK_ALWAYS = 0;
    localparam int ACK_LOW    = 1;
    localparam int ACK_RANDOM = 2;

    logic      CP;
    logic      MR;
    logic      send_in;
    logic      ack_out;
    logic      load_flg;
    logic      write_en;
    data_t     write_data;
    packet_t   packet_in;
    logic      send_out;
    logic      ack_in;
    packet_t   packet_out;
    reg_addr_t rd_addr;
    data_t     rd_data;

    // reference models
    data_t     mem_model [`MA_DMEM_DEPTH];
    logic      written [`MA_DMEM_DEPTH];
    data_t     reg_model [`MA_REG_COUNT];
    packet_t   exp_q [$];
    packet_t   mon_pkt;

    int        ack_mode;
    int        errors;
    int        checks;
    int        sent;
    int        received;
    int        cycles;
    logic [15:0] lfsr_state;

    ma_wb_top i_dut (
        .CP         (CP),
        .MR         (MR),
        .send_in    (send_in),
        .ack_out    (ack_out),
        .load_flg   (load_flg),
        .write_en   (write_en),
        .write_data (write_data),
        .packet_in  (packet_in),
        .send_out   (send_out),
        .ack_in     (ack_in),
        .packet_out (packet_out),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // 4 ns clock
    always #2 CP = ~CP;

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [39:0] rand_bits(input int n);
        logic [39:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[38:0], next_bit()};
        end
        return v;
    endfunction

    function automatic packet_t make_packet(input other_t other, input logic reg_wr,
                                            input reg_addr_t dest, input data_t low);
        packet_t p;
        p = {other, low};
        p[`MA_REG_WE_BIT] = reg_wr;
        p[`MA_REG_DEST_LSB +: `MA_REG_ADDR_W] = dest;
        return p;
    endfunction

    task automatic check_packet(input packet_t got, input packet_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_word(input data_t got, input data_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // consumer, ack changes just after the edge
    always @(posedge CP) begin
        #0.5;
        if (ack_mode == ACK_RANDOM) begin
            ack_in = next_bit();
        end else begin
            ack_in = (ack_mode == ACK_ALWAYS);
        end
    end

    // output monitor, a hand-off seen here happens on the next edge
    always @(negedge CP) begin
        if (!MR && send_out && ack_in) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Packet %h came out at %0t ns with nothing outstanding",
                         packet_out, $time);
            end else begin
                mon_pkt = exp_q.pop_front();
                check_packet(packet_out, mon_pkt, "output packet");
                if (mon_pkt[`MA_REG_WE_BIT]) begin
                    reg_model[mon_pkt[`MA_REG_DEST_LSB +: `MA_REG_ADDR_W]] =
                        mon_pkt[`MA_DATA_W-1:0];
                end
                received++;
            end
        end
    end

    always @(posedge CP) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // offer one packet, return just after the edge that takes it
    task automatic send_packet(input packet_t pkt, input logic load, input logic wr,
                               input data_t wdata);
        packet_t exp;
        send_in    = 1'b1;
        packet_in  = pkt;
        load_flg   = load;
        write_en   = wr;
        write_data = wdata;
        @(negedge CP);
        while (!ack_out) begin
            @(negedge CP);
        end
        // model the memory access in acceptance order
        exp = pkt;
        if (wr) begin
            mem_model[pkt[`MA_DMEM_ADDR_W-1:0]] = wdata;
        end
        if (load) begin
            exp[`MA_DATA_W-1:0] = mem_model[pkt[`MA_DMEM_ADDR_W-1:0]];
        end
        exp_q.push_back(exp);
        sent++;
        @(posedge CP);
        #0.5;
        send_in  = 1'b0;
        load_flg = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge CP);
        end
        // last register write lands on this edge
        @(posedge CP);
        #0.5;
    endtask

    task automatic check_regs(input string msg);
        for (int i = 0; i < `MA_REG_COUNT; i++) begin
            rd_addr = reg_addr_t'(i);
            @(negedge CP);
            check_word(rd_data, reg_model[i], $sformatf("%s reg %0d", msg, i));
            @(posedge CP);
            #0.5;
        end
    endtask

    task automatic reset_values();
        @(negedge CP);
        check_flag(ack_out, 1'b1, "ack_out after reset");
        check_flag(send_out, 1'b0, "send_out after reset");
        @(posedge CP);
        #0.5;
        check_regs("reset");
    endtask

    task automatic pass_through();
        send_packet(make_packet(24'h5A0000, 1'b0, 4'h2, 16'h0001), 1'b0, 1'b0, 16'h0);
        send_packet(make_packet(24'hA5FF00, 1'b0, 4'h9, 16'hFFFF), 1'b0, 1'b0, 16'h0);
        send_packet(make_packet(24'h123400, 1'b0, 4'hF, 16'h8000), 1'b0, 1'b0, 16'h0);
        send_packet(make_packet(24'h000000, 1'b0, 4'h0, 16'h0000), 1'b0, 1'b0, 16'h0);
        wait_drain();
    endtask

    task automatic store_then_load();
        send_packet(make_packet(24'h3A0000, 1'b0, 4'h0, 16'h0155), 1'b0, 1'b1, 16'hBEEF);
        send_packet(make_packet(24'h3A0000, 1'b0, 4'h0, 16'h02AA), 1'b0, 1'b1, 16'h1234);
        send_packet(make_packet(24'hC0FFE0, 1'b0, 4'h0, 16'h0155), 1'b1, 1'b0, 16'h0);
        // loaded word also goes to r3
        send_packet(make_packet(24'h7E0000, 1'b1, 4'h3, 16'h02AA), 1'b1, 1'b0, 16'h0);
        // overwrite then read back
        send_packet(make_packet(24'h3A0000, 1'b0, 4'h0, 16'hFD55), 1'b0, 1'b1, 16'h5A5A);
        send_packet(make_packet(24'h990000, 1'b0, 4'h0, 16'hFD55), 1'b1, 1'b0, 16'h0);
        wait_drain();
        check_regs("store/load");
    endtask

    task automatic back_pressure();
        ack_mode = ACK_LOW;
        @(posedge CP);
        #0.5;
        send_packet(make_packet(24'h100000, 1'b0, 4'h0, 16'h0A0A), 1'b0, 1'b0, 16'h0);
        check_flag(ack_out, 1'b1, "ack_out with one packet held");
        send_packet(make_packet(24'h200000, 1'b0, 4'h0, 16'h0B0B), 1'b0, 1'b0, 16'h0);
        @(negedge CP);
        check_flag(ack_out, 1'b0, "ack_out with two packets held");
        check_flag(send_out, 1'b1, "send_out with two packets held");
        @(posedge CP);
        #0.5;
        fork
            begin
                send_packet(make_packet(24'h300000, 1'b0, 4'h0, 16'h0C0C), 1'b0, 1'b0, 16'h0);
                send_packet(make_packet(24'h400000, 1'b0, 4'h0, 16'h0D0D), 1'b0, 1'b0, 16'h0);
            end
            begin
                repeat (4) @(posedge CP);
                ack_mode = ACK_ALWAYS;
            end
        join
        wait_drain();
    endtask

    task automatic register_write_back();
        send_packet(make_packet(24'h000000, 1'b1, 4'h1, 16'h1111), 1'b0, 1'b0, 16'h0);
        send_packet(make_packet(24'hFF0000, 1'b1, 4'h7, 16'h7777), 1'b0, 1'b0, 16'h0);
        send_packet(make_packet(24'h0F0000, 1'b1, 4'hF, 16'hF00F), 1'b0, 1'b0, 16'h0);
        // write bit clear, r7 must keep its value
        send_packet(make_packet(24'hFF0000, 1'b0, 4'h7, 16'hDEAD), 1'b0, 1'b0, 16'h0);
        send_packet(make_packet(24'h000000, 1'b1, 4'h1, 16'h2222), 1'b0, 1'b0, 16'h0);
        wait_drain();
        check_regs("write-back");
    endtask

    task automatic random_stream();
        packet_t    pkt [RND_COUNT];
        logic       ld [RND_COUNT];
        logic       wr [RND_COUNT];
        data_t      wdata [RND_COUNT];
        logic [1:0] op;
        dmem_addr_t addr;
        for (int n = 0; n < RND_COUNT; n++) begin
            op = 2'(rand_bits(2));
            pkt[n] = packet_t'(rand_bits(40));
            // sixteen shared addresses so loads hit earlier stores
            pkt[n][9:4] = '0;
            addr = pkt[n][`MA_DMEM_ADDR_W-1:0];
            wdata[n] = data_t'(rand_bits(16));
            ld[n] = (op == 2'd0);
            wr[n] = (op == 2'd1);
            // never load a word that was not stored
            if (ld[n] && !written[addr]) begin
                ld[n] = 1'b0;
                wr[n] = 1'b1;
            end
            if (wr[n]) begin
                written[addr] = 1'b1;
            end
        end
        ack_mode = ACK_RANDOM;
        for (int n = 0; n < RND_COUNT; n++) begin
            send_packet(pkt[n], ld[n], wr[n], wdata[n]);
        end
        wait_drain();
        ack_mode = ACK_ALWAYS;
        check_regs("random");
    endtask

    initial begin
        CP = 1'b0;
        MR = 1'b1;
        send_in = 1'b0;
        load_flg = 1'b0;
        write_en = 1'b0;
        write_data = '0;
        packet_in = '0;
        ack_in = 1'b1;
        rd_addr = '0;
        ack_mode = ACK_ALWAYS;
        lfsr_state = 16'd51;
        errors = 0;
        checks = 0;
        sent = 0;
        received = 0;
        cycles = 0;
        for (int i = 0; i < `MA_DMEM_DEPTH; i++) begin
            written[i] = 1'b0;
        end
        for (int i = 0; i < `MA_REG_COUNT; i++) begin
            reg_model[i] = '0;
        end
        repeat (2) @(posedge CP);
        #0.5;
        MR = 1'b0;
        reset_values();
        pass_through();
        store_then_load();
        back_pressure();
        register_write_back();
        random_stream();
        if (sent != received) begin
            errors++;
            $display("Sent %0d packets but %0d came out", sent, received);
        end
        $display("Checks: %0d, errors: %0d, packets sent: %0d, received: %0d",
                 checks, errors, sent, received);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
